//--- Makefile
VERILATOR  ?= verilator
TB_TOP     := tb_slam_nonlinear
RTL_TOP    := slam_nonlinear_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
verilog/slam_pkg.sv
verilog/cordic_if.sv
verilog/div_if.sv
verilog/cordic_dual_mode.sv
verilog/fixed_divider.sv
verilog/nonlinear_core.sv
verilog/slam_nonlinear_top.sv
sim/tb_slam_nonlinear.sv

//--- sim/tb_slam_nonlinear.sv
module tb_slam_nonlinear;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic signed [slam_pkg::data_w-1:0] data_t;
    typedef logic signed [slam_pkg::angle_w-1:0] angle_t;

    localparam real data_scale = 524288.0;
    localparam real angle_scale = 32768.0;
    localparam int done_timeout = 1000;
    localparam int sets = 20;
    localparam logic [15:0] lfsr_seed = 16'd49;

    localparam int k_none = 0;
    localparam int k_predict = 1;
    localparam int k_newlm = 2;
    localparam int k_update = 3;

    // vehicle constants, same shift-add sums as the core
    localparam real dt = 1.0/8 - 1.0/32 + 1.0/128 - 1.0/512 + 1.0/2048 - 1.0/8192 + 1.0/32768;
    localparam real dt_a_l = 1.0/8 + 1.0/128 + 1.0/1024 - 1.0/4096 + 1.0/32768;
    localparam real dt_b_l = 1.0/64 + 1.0/512 + 1.0/16384 + 1.0/32768;
    localparam real h_l = 1.0/4 + 1.0/64 + 1.0/512 + 1.0/1024;

    logic clk, rst;
    logic init_predict, init_newlm, init_update;
    data_t vlr, rk, lkx, lky, xk, yk;
    angle_t alpha, xita, phi;
    logic done_predict, done_newlm, done_update;
    data_t result_0, result_1, result_2, result_3, result_4, result_5;

    logic [15:0] lfsr;
    logic started, aborted;
    int expect_kind;
    int checks, value_errors, protocol_errors, timeouts;
    int issued, total_dones;

    slam_nonlinear_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && (done_predict || done_newlm || done_update))
            total_dones++;
    end

    task automatic note_protocol(input string what);
        protocol_errors++;
        $display("protocol error at %0t ns: %s", $time, what);
    endtask

    a_pred_pulse: assert property (@(posedge clk) disable iff (rst) done_predict |=> !done_predict)
        else note_protocol("done_predict held longer than one cycle");
    a_newlm_pulse: assert property (@(posedge clk) disable iff (rst) done_newlm |=> !done_newlm)
        else note_protocol("done_newlm held longer than one cycle");
    a_upd_pulse: assert property (@(posedge clk) disable iff (rst) done_update |=> !done_update)
        else note_protocol("done_update held longer than one cycle");
    a_one_done: assert property (@(posedge clk) disable iff (rst)
                                 $onehot0({done_predict, done_newlm, done_update}))
        else note_protocol("more than one done high together");
    a_pred_match: assert property (@(posedge clk) disable iff (rst)
                                   done_predict |-> expect_kind == k_predict)
        else note_protocol("done_predict without an accepted predict request");
    a_newlm_match: assert property (@(posedge clk) disable iff (rst)
                                    done_newlm |-> expect_kind == k_newlm)
        else note_protocol("done_newlm without an accepted newlm request");
    a_upd_match: assert property (@(posedge clk) disable iff (rst)
                                  done_update |-> expect_kind == k_update)
        else note_protocol("done_update without an accepted update request");
    // idle state before the first request
    a_reset_idle: assert property (@(posedge clk) disable iff (rst) !started |->
        (result_0 == 0 && result_1 == 0 && result_2 == 0 && result_3 == 0 &&
         result_4 == 0 && result_5 == 0 && !done_predict && !done_newlm && !done_update))
        else note_protocol("outputs not idle after reset");

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], lfsr_step()};
        return v;
    endfunction

    function automatic real random_real(input real lo, input real hi);
        return lo + (hi - lo) * $itor(random_bits(16)) / 65536.0;
    endfunction

    function automatic data_t data_word(input real v);
        return data_t'($rtoi(v * data_scale));
    endfunction

    function automatic angle_t angle_word(input real v);
        return angle_t'($rtoi(v * angle_scale));
    endfunction

    function automatic string done_name(input int kind);
        case (kind)
            k_predict: return "done_predict";
            k_newlm:   return "done_newlm";
            default:   return "done_update";
        endcase
    endfunction

    task automatic check_value(input string name, input data_t actual,
                               input real expected, input real tol);
        real act_r;
        data_t exp_fx;
        act_r = $itor(actual) / data_scale;
        exp_fx = data_word(expected);
        checks++;
        assert (act_r - expected <= tol && expected - act_r <= tol)
        else begin
            value_errors++;
            $display("FAIL %s expected %h actual %h", name, exp_fx, actual);
        end
    endtask

    task automatic wait_for_done(input int kind);
        int cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
            seen = (kind == k_predict) ? done_predict :
                   (kind == k_newlm) ? done_newlm : done_update;
        end
        if (!seen) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout: %s never came within %0d cycles", done_name(kind), done_timeout);
        end
    endtask

    // strobe at a drive point, optionally strobing again while busy
    task automatic run_request(input int kind, input logic together, input logic again);
        expect_kind = kind;
        started = 1'b1;
        issued++;
        init_predict = together || kind == k_predict;
        init_newlm = together || kind == k_newlm;
        init_update = together || kind == k_update;
        @(posedge clk);
        #1;
        {init_predict, init_newlm, init_update} = 3'b000;
        if (again) begin
            repeat (3) @(posedge clk);
            #1;
            {init_predict, init_newlm, init_update} = 3'b111;
            @(posedge clk);
            #1;
            {init_predict, init_newlm, init_update} = 3'b000;
        end
        wait_for_done(kind);
    endtask

    // done stays visible to the assertions through the next edge
    task automatic retire();
        @(posedge clk);
        #1;
        expect_kind = k_none;
    endtask

    task automatic set_predict_operands();
        vlr = data_word(random_real(0.0, 4.0));
        alpha = angle_word(random_real(-1.2, 1.2));
        xita = angle_word(random_real(-1.2, 1.2));
    endtask

    task automatic set_newlm_operands();
        // phi + xita stays inside the CORDIC range
        phi = angle_word(random_real(-0.6, 0.6));
        xita = angle_word(random_real(-0.6, 0.6));
        rk = data_word(random_real(0.5, 50.0));
    endtask

    task automatic set_update_operands();
        real dy;
        xk = data_word(random_real(-50.0, 50.0));
        yk = data_word(random_real(-50.0, 50.0));
        dy = random_real(0.5, 40.0);
        if (lfsr_step())
            dy = -dy;
        // dx positive keeps the bearing within vectoring convergence
        lkx = xk + data_word(random_real(0.5, 40.0));
        lky = yk + data_word(dy);
    endtask

    task automatic check_predict();
        real v, a, x, t, vc;
        v = $itor(vlr) / data_scale;
        a = $itor(alpha) / angle_scale;
        x = $itor(xita) / angle_scale;
        t = $tan(a);
        vc = v / (1.0 - h_l * t);
        check_value("result_1", result_1, dt * vc, 0.03);
        check_value("result_2", result_2,
                    dt * vc * $cos(x) - dt_a_l * vc * $sin(x) * t - dt_b_l * vc * $cos(x) * t,
                    0.03);
        check_value("result_3", result_3,
                    dt * vc * $sin(x) + dt_a_l * vc * $cos(x) * t - dt_b_l * vc * $sin(x) * t,
                    0.03);
    endtask

    task automatic check_newlm();
        real g, r;
        g = ($itor(phi) + $itor(xita)) / angle_scale;
        r = $itor(rk) / data_scale;
        check_value("result_0", result_0, $cos(g), 0.002);
        check_value("result_1", result_1, $sin(g), 0.002);
        check_value("result_2", result_2, r * $sin(g), 0.002 + 0.0005 * r);
        check_value("result_3", result_3, r * $cos(g), 0.002 + 0.0005 * r);
    endtask

    task automatic check_update();
        real dx, dy, d;
        dx = $itor(lkx - xk) / data_scale;
        dy = $itor(lky - yk) / data_scale;
        d = $sqrt(dx * dx + dy * dy);
        check_value("result_0", result_0, d, 0.01 + 0.001 * d);
        check_value("result_1", result_1, $atan2(dy, dx), 0.002);
        check_value("result_2", result_2, dy / (d * d), 0.002);
        check_value("result_3", result_3, dx / (d * d), 0.002);
        check_value("result_4", result_4, dx / d, 0.002);
        check_value("result_5", result_5, dy / d, 0.002);
    endtask

    task automatic run_sets(input int kind);
        for (int i = 0; i < sets && !aborted; i++) begin
            case (kind)
                k_predict: set_predict_operands();
                k_newlm:   set_newlm_operands();
                default:   set_update_operands();
            endcase
            run_request(kind, 1'b0, 1'b0);
            if (!aborted) begin
                case (kind)
                    k_predict: check_predict();
                    k_newlm:   check_newlm();
                    default:   check_update();
                endcase
            end
            retire();
        end
    endtask

    task automatic run_overlap();
        set_predict_operands();
        set_update_operands();
        // all strobes at once, predict is served
        run_request(k_predict, 1'b1, 1'b0);
        if (!aborted)
            check_predict();
        retire();
        set_newlm_operands();
        run_request(k_newlm, 1'b0, 1'b1);
        if (!aborted)
            check_newlm();
        retire();
        // quiet window, any late done trips the match assertions
        repeat (300) @(posedge clk);
        #1;
    endtask

    task automatic report_and_finish();
        if (!aborted) begin
            assert (total_dones == issued)
            else begin
                protocol_errors++;
                $display("%0d done pulses seen for %0d accepted requests", total_dones, issued);
            end
        end
        $display("checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 checks, value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        {init_predict, init_newlm, init_update} = 3'b000;
        vlr = '0;
        rk = '0;
        lkx = '0;
        lky = '0;
        xk = '0;
        yk = '0;
        alpha = '0;
        xita = '0;
        phi = '0;
        lfsr = lfsr_seed;
        started = 1'b0;
        aborted = 1'b0;
        expect_kind = k_none;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // a few idle cycles before the first request
        repeat (5) @(posedge clk);
        #1;
        run_sets(k_predict);
        run_sets(k_newlm);
        run_sets(k_update);
        if (!aborted)
            run_overlap();
        report_and_finish();
    end

endmodule

//--- verilog/cordic_dual_mode.sv
module cordic_dual_mode #(
    parameter int iter = slam_pkg::cordic_iter
) (
    input logic clk,
    input logic rst,
    cordic_if.engine cif
);

    localparam int aw    = slam_pkg::angle_w;
    localparam int cnt_w = $clog2(iter + 1);

    logic signed [aw-1:0] x, y, z;
    logic signed [aw-1:0] x_sh, y_sh;
    logic signed [2*aw-1:0] x_gain, y_gain;
    logic [cnt_w-1:0] cnt;
    logic busy, gain_step, mode_r, dir;

    // dir high means rotate counter-clockwise
    always_comb begin
        x_sh = x >>> cnt;
        y_sh = y >>> cnt;
        dir = mode_r ? y[aw-1] : ~z[aw-1];
        x_gain = x * slam_pkg::cordic_gain_inv;
        y_gain = y * slam_pkg::cordic_gain_inv;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            gain_step <= 1'b0;
            cnt <= '0;
            cif.done <= 1'b0;
        end else begin
            cif.done <= 1'b0;
            if (cif.init) begin
                busy <= 1'b1;
                gain_step <= 1'b0;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_w'(iter - 1)) begin
                    busy <= 1'b0;
                    gain_step <= 1'b1;
                end
            end else if (gain_step) begin
                gain_step <= 1'b0;
                cif.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cif.init) begin
            x <= cif.xin;
            y <= cif.yin;
            z <= cif.zin;
            mode_r <= cif.mode;
        end else if (busy) begin
            if (dir) begin
                x <= x - y_sh;
                y <= y + x_sh;
                z <= z - slam_pkg::atan_table(int'(cnt));
            end else begin
                x <= x + y_sh;
                y <= y - x_sh;
                z <= z + slam_pkg::atan_table(int'(cnt));
            end
        end else if (gain_step) begin
            // remove the accumulated CORDIC gain
            x <= x_gain[slam_pkg::cordic_frac +: aw];
            y <= y_gain[slam_pkg::cordic_frac +: aw];
        end
    end

    assign cif.xout = x;
    assign cif.yout = y;
    assign cif.zout = z;

endmodule

//--- verilog/cordic_if.sv
interface cordic_if;
    logic init;
    // 0 rotation, 1 vectoring
    logic mode;
    logic signed [slam_pkg::angle_w-1:0] xin, yin, zin;
    logic done;
    logic signed [slam_pkg::angle_w-1:0] xout, yout, zout;

    modport requester (
        output init, mode, xin, yin, zin,
        input  done, xout, yout, zout
    );

    modport engine (
        input  init, mode, xin, yin, zin,
        output done, xout, yout, zout
    );
endinterface

//--- verilog/div_if.sv
interface div_if;
    logic start;
    logic signed [slam_pkg::data_w-1:0] dividend, divisor;
    logic signed [slam_pkg::data_w-1:0] quotient;
    logic valid;

    modport requester (
        output start, dividend, divisor,
        input  quotient, valid
    );

    modport engine (
        input  start, dividend, divisor,
        output quotient, valid
    );
endinterface

//--- verilog/fixed_divider.sv
module fixed_divider (
    input logic clk,
    input logic rst,
    div_if.engine dif
);

    localparam int dw    = slam_pkg::data_w;
    localparam int num_w = slam_pkg::data_w + slam_pkg::frac_bits;

    logic [num_w-1:0] num, quo, quo_nxt;
    logic [dw:0] rem, rem_nxt;
    logic [dw+1:0] diff;
    logic [dw-1:0] den, abs_a, abs_b, mag;
    logic [5:0] cnt;
    logic busy, neg, div_zero;

    always_comb begin
        abs_a = dif.dividend[dw-1] ? (~dif.dividend + 1'b1) : dif.dividend;
        abs_b = dif.divisor[dw-1] ? (~dif.divisor + 1'b1) : dif.divisor;
        // trial subtract of the divisor from the shifted remainder
        diff = {rem, num[num_w-1]} - {2'b00, den};
        rem_nxt = diff[dw+1] ? {rem[dw-1:0], num[num_w-1]} : diff[dw:0];
        quo_nxt = {quo[num_w-2:0], ~diff[dw+1]};
        // saturate once the magnitude leaves Q12.19
        if (div_zero || quo_nxt[num_w-1:dw-1] != '0)
            mag = {1'b0, {(dw-1){1'b1}}};
        else
            mag = quo_nxt[dw-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
            dif.valid <= 1'b0;
        end else begin
            dif.valid <= 1'b0;
            if (dif.start) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == 6'(num_w - 1)) begin
                    busy <= 1'b0;
                    dif.valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dif.start) begin
            num <= {abs_a, {slam_pkg::frac_bits{1'b0}}};
            den <= abs_b;
            rem <= '0;
            quo <= '0;
            div_zero <= (abs_b == '0);
            neg <= (abs_b == '0) ? dif.dividend[dw-1]
                                 : (dif.dividend[dw-1] ^ dif.divisor[dw-1]);
        end else if (busy) begin
            num <= num << 1;
            rem <= rem_nxt;
            quo <= quo_nxt;
            if (cnt == 6'(num_w - 1))
                dif.quotient <= neg ? -$signed(mag) : $signed(mag);
        end
    end

endmodule

//--- verilog/nonlinear_core.sv
module nonlinear_core (
    input logic clk,
    input logic rst,
    input logic init_predict,
    input logic init_newlm,
    input logic init_update,
    input logic signed [slam_pkg::data_w-1:0] vlr, rk, lkx, lky, xk, yk,
    input logic signed [slam_pkg::angle_w-1:0] alpha, xita, phi,
    cordic_if.requester cif,
    div_if.requester dif,
    output logic done_predict,
    output logic done_newlm,
    output logic done_update,
    output logic signed [slam_pkg::data_w-1:0] result_0, result_1, result_2,
    output logic signed [slam_pkg::data_w-1:0] result_3, result_4, result_5
);

    localparam int dw = slam_pkg::data_w;
    localparam int fb = slam_pkg::frac_bits;
    // shift from angle format up to data format
    localparam int up = slam_pkg::frac_bits - slam_pkg::cordic_frac;

    typedef logic signed [dw-1:0] word_t;

    slam_pkg::core_state_t state, state_nxt;

    word_t mul_a, mul_b, prod, dx, dy, abs_dx, abs_dy, span;
    logic signed [2*dw-1:0] prod_full;
    logic [3:0] scale;

    function automatic word_t to_data(input logic signed [slam_pkg::angle_w-1:0] v);
        word_t t;
        t = v;
        return t <<< up;
    endfunction

    // vehicle constants as shift-add sums
    function automatic word_t k_dt(input word_t v);
        return (v >>> 3) - (v >>> 5) + (v >>> 7) - (v >>> 9)
             + (v >>> 11) - (v >>> 13) + (v >>> 15);
    endfunction

    function automatic word_t k_dt_a_l(input word_t v);
        return (v >>> 3) + (v >>> 7) + (v >>> 10) - (v >>> 12) + (v >>> 15);
    endfunction

    function automatic word_t k_dt_b_l(input word_t v);
        return (v >>> 6) + (v >>> 9) + (v >>> 14) + (v >>> 15);
    endfunction

    function automatic word_t k_h_l(input word_t v);
        return (v >>> 2) + (v >>> 6) + (v >>> 9) + (v >>> 10);
    endfunction

    // leading-bit scale of the update difference vector
    always_comb begin
        dx = lkx - xk;
        dy = lky - yk;
        abs_dx = dx[dw-1] ? -dx : dx;
        abs_dy = dy[dw-1] ? -dy : dy;
        span = abs_dx | abs_dy;
        scale = '0;
        for (int i = fb; i < dw - 1; i++) begin
            if (span[i])
                scale = 4'(i - fb + 1);
        end
    end

    // shared multiplier
    always_comb begin
        mul_a = result_1;
        mul_b = result_0;
        case (state)
            slam_pkg::s_vcsin:    mul_b = result_3;
            slam_pkg::s_vccos:    mul_b = result_2;
            slam_pkg::s_vcsintan: mul_a = result_3;
            slam_pkg::s_vccostan: mul_a = result_2;
            slam_pkg::s_rksin: begin
                mul_a = rk;
                mul_b = result_1;
            end
            slam_pkg::s_rkcos:    mul_a = rk;
            slam_pkg::s_d2:       mul_a = result_0;
            default: ;
        endcase
        prod_full = mul_a * mul_b;
        prod = {prod_full[2*dw-1], prod_full[fb+dw-2:fb]};
    end

    always_comb begin
        state_nxt = state;
        case (state)
            slam_pkg::s_idle:
                if (init_predict)
                    state_nxt = slam_pkg::s_rotate_alpha;
                else if (init_newlm)
                    state_nxt = slam_pkg::s_rotate_gamma;
                else if (init_update)
                    state_nxt = slam_pkg::s_vector;
            slam_pkg::s_rotate_alpha: if (cif.done) state_nxt = slam_pkg::s_tanalpha;
            slam_pkg::s_tanalpha:     if (dif.valid) state_nxt = slam_pkg::s_vc;
            slam_pkg::s_vc:           if (dif.valid) state_nxt = slam_pkg::s_rotate_xita;
            slam_pkg::s_rotate_xita:  if (cif.done) state_nxt = slam_pkg::s_vcsin;
            slam_pkg::s_vcsin:        state_nxt = slam_pkg::s_vccos;
            slam_pkg::s_vccos:        state_nxt = slam_pkg::s_vctan;
            slam_pkg::s_vctan:        state_nxt = slam_pkg::s_vcsintan;
            slam_pkg::s_vcsintan:     state_nxt = slam_pkg::s_vccostan;
            slam_pkg::s_vccostan:     state_nxt = slam_pkg::s_result_pre;
            slam_pkg::s_rotate_gamma: if (cif.done) state_nxt = slam_pkg::s_rksin;
            slam_pkg::s_rksin:        state_nxt = slam_pkg::s_rkcos;
            slam_pkg::s_rkcos:        state_nxt = slam_pkg::s_result_newlm;
            slam_pkg::s_vector:       if (cif.done) state_nxt = slam_pkg::s_d2;
            slam_pkg::s_d2:           state_nxt = slam_pkg::s_dx_d2;
            slam_pkg::s_dx_d2:        if (dif.valid) state_nxt = slam_pkg::s_dy_d2;
            slam_pkg::s_dy_d2:        if (dif.valid) state_nxt = slam_pkg::s_dx_d;
            slam_pkg::s_dx_d:         if (dif.valid) state_nxt = slam_pkg::s_dy_d;
            slam_pkg::s_dy_d:         if (dif.valid) state_nxt = slam_pkg::s_result_update;
            default:                  state_nxt = slam_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= slam_pkg::s_idle;
            cif.init <= 1'b0;
            dif.start <= 1'b0;
            done_predict <= 1'b0;
            done_newlm <= 1'b0;
            done_update <= 1'b0;
        end else begin
            state <= state_nxt;
            cif.init <= (state != state_nxt) &&
                        (state_nxt inside {slam_pkg::s_rotate_alpha, slam_pkg::s_rotate_xita,
                                           slam_pkg::s_rotate_gamma, slam_pkg::s_vector});
            dif.start <= (state != state_nxt) &&
                         (state_nxt inside {slam_pkg::s_tanalpha, slam_pkg::s_vc,
                                            slam_pkg::s_dx_d2, slam_pkg::s_dy_d2,
                                            slam_pkg::s_dx_d, slam_pkg::s_dy_d});
            done_predict <= (state == slam_pkg::s_result_pre);
            done_newlm <= (state == slam_pkg::s_result_newlm);
            done_update <= (state == slam_pkg::s_result_update);
        end
    end

    // CORDIC and divider operands, loaded on the step transition
    always_ff @(posedge clk) begin
        if (state != state_nxt) begin
            cif.mode <= 1'b0;
            cif.xin <= slam_pkg::cordic_one;
            cif.yin <= '0;
            case (state_nxt)
                slam_pkg::s_rotate_alpha: cif.zin <= alpha;
                slam_pkg::s_rotate_xita:  cif.zin <= xita;
                slam_pkg::s_rotate_gamma: cif.zin <= phi + xita;
                slam_pkg::s_vector: begin
                    // one spare bit keeps K times the magnitude below 2
                    cif.mode <= 1'b1;
                    cif.xin <= slam_pkg::angle_w'(dx >>> (up + 1 + scale));
                    cif.yin <= slam_pkg::angle_w'(dy >>> (up + 1 + scale));
                    cif.zin <= '0;
                end
                default: ;
            endcase
            case (state_nxt)
                slam_pkg::s_tanalpha: begin
                    dif.dividend <= to_data(cif.yout);
                    dif.divisor <= to_data(cif.xout);
                end
                slam_pkg::s_vc: begin
                    // vc = v / (1 - H/L * tan(alpha))
                    dif.dividend <= vlr;
                    dif.divisor <= word_t'(1 <<< fb) - k_h_l(dif.quotient);
                end
                slam_pkg::s_dx_d2: begin
                    dif.dividend <= dx;
                    dif.divisor <= prod;
                end
                slam_pkg::s_dy_d2: begin
                    dif.dividend <= dy;
                    dif.divisor <= result_2;
                end
                slam_pkg::s_dx_d, slam_pkg::s_dy_d: begin
                    dif.dividend <= (state_nxt == slam_pkg::s_dx_d) ? dx : dy;
                    dif.divisor <= result_0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_0 <= '0;
            result_1 <= '0;
            result_2 <= '0;
            result_3 <= '0;
            result_4 <= '0;
            result_5 <= '0;
        end else begin
            case (state)
                slam_pkg::s_tanalpha: if (dif.valid) result_0 <= dif.quotient;
                slam_pkg::s_vc:       if (dif.valid) result_1 <= dif.quotient;
                slam_pkg::s_rotate_xita, slam_pkg::s_rotate_gamma: begin
                    if (cif.done && state == slam_pkg::s_rotate_xita) begin
                        result_2 <= to_data(cif.xout);
                        result_3 <= to_data(cif.yout);
                    end else if (cif.done) begin
                        result_0 <= to_data(cif.xout);
                        result_1 <= to_data(cif.yout);
                    end
                end
                slam_pkg::s_vcsin:    result_3 <= prod;
                slam_pkg::s_vccos:    result_2 <= prod;
                slam_pkg::s_vctan:    result_5 <= prod;
                slam_pkg::s_vcsintan: result_4 <= prod;
                slam_pkg::s_vccostan: result_0 <= prod;
                slam_pkg::s_result_pre: begin
                    // result_0 holds vc*cos*tan, result_4 vc*sin*tan
                    result_1 <= k_dt(result_1);
                    result_2 <= k_dt(result_2) - k_dt_a_l(result_4) - k_dt_b_l(result_0);
                    result_3 <= k_dt(result_3) + k_dt_a_l(result_0) - k_dt_b_l(result_4);
                end
                slam_pkg::s_rksin: result_2 <= prod;
                slam_pkg::s_rkcos: result_3 <= prod;
                slam_pkg::s_vector: begin
                    if (cif.done) begin
                        // undo the input normalisation
                        result_0 <= to_data(cif.xout) <<< (1 + scale);
                        result_1 <= to_data(cif.zout);
                    end
                end
                slam_pkg::s_d2:    result_2 <= prod;
                slam_pkg::s_dx_d2: if (dif.valid) result_3 <= dif.quotient;
                slam_pkg::s_dy_d2: if (dif.valid) result_2 <= dif.quotient;
                slam_pkg::s_dx_d:  if (dif.valid) result_4 <= dif.quotient;
                slam_pkg::s_dy_d:  if (dif.valid) result_5 <= dif.quotient;
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/slam_nonlinear_top.sv
module slam_nonlinear_top (
    input logic clk,
    input logic rst,
    input logic init_predict,
    input logic init_newlm,
    input logic init_update,
    input logic signed [slam_pkg::data_w-1:0] vlr, rk, lkx, lky, xk, yk,
    input logic signed [slam_pkg::angle_w-1:0] alpha, xita, phi,
    output logic done_predict,
    output logic done_newlm,
    output logic done_update,
    output logic signed [slam_pkg::data_w-1:0] result_0, result_1, result_2,
    output logic signed [slam_pkg::data_w-1:0] result_3, result_4, result_5
);

    cordic_if cif ();
    div_if dif ();

    nonlinear_core core (
        .clk(clk),
        .rst(rst),
        .init_predict(init_predict),
        .init_newlm(init_newlm),
        .init_update(init_update),
        .vlr(vlr),
        .rk(rk),
        .lkx(lkx),
        .lky(lky),
        .xk(xk),
        .yk(yk),
        .alpha(alpha),
        .xita(xita),
        .phi(phi),
        .cif(cif.requester),
        .dif(dif.requester),
        .done_predict(done_predict),
        .done_newlm(done_newlm),
        .done_update(done_update),
        .result_0(result_0),
        .result_1(result_1),
        .result_2(result_2),
        .result_3(result_3),
        .result_4(result_4),
        .result_5(result_5)
    );

    cordic_dual_mode cordic (
        .clk(clk),
        .rst(rst),
        .cif(cif.engine)
    );

    fixed_divider divider (
        .clk(clk),
        .rst(rst),
        .dif(dif.engine)
    );

endmodule

//--- verilog/slam_pkg.sv
package slam_pkg;

    // Q1.12.19 data words
    localparam int data_w    = 32;
    localparam int frac_bits = 19;

    // Q1.1.15 CORDIC words
    localparam int angle_w     = 17;
    localparam int cordic_frac = 15;
    localparam int cordic_iter = 14;

    localparam logic signed [angle_w-1:0] cordic_one      = 17'sd32768;
    // 1/K, K being the gain after cordic_iter micro-rotations
    localparam logic signed [angle_w-1:0] cordic_gain_inv = 17'sd19898;

    localparam int div_cycles = 52;

    function automatic logic signed [angle_w-1:0] atan_table(input int i);
        case (i)
            0:       return 17'sd25736;
            1:       return 17'sd15193;
            2:       return 17'sd8027;
            3:       return 17'sd4075;
            4:       return 17'sd2045;
            5:       return 17'sd1024;
            default: return (i < 16) ? (17'sd32768 >>> i) : 17'sd0;
        endcase
    endfunction

    typedef enum logic [4:0] {
        s_idle,
        s_rotate_alpha, s_tanalpha, s_vc, s_rotate_xita,
        s_vcsin, s_vccos, s_vctan, s_vcsintan, s_vccostan, s_result_pre,
        s_rotate_gamma, s_rksin, s_rkcos, s_result_newlm,
        s_vector, s_d2, s_dx_d2, s_dy_d2, s_dx_d, s_dy_d, s_result_update
    } core_state_t;

endpackage
